/* kicker_video.f */
+incdir+source
source/kicker_pkg.sv
source/kicker_vtimer.sv
source/kicker_vram_arb.sv
source/kicker_apb_vram.sv
source/kicker_tilemap.sv
source/kicker_video.sv
bench/kicker_video_asserts.sv
bench/kicker_video_tb.sv

/* Makefile */
# Verilator flow for the kicker video block and its testbench

TOP := kicker_video_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f kicker_video.f --top-module $(TOP)

# the run exits non-zero when the testbench stops on $fatal
sim:
	verilator --binary --timing --assert -f kicker_video.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir

/* bench/kicker_video_tb.sv */
// kicker video testbench
`timescale 1ns/10ps
`include "kicker_consts.svh"
`default_nettype none

module kicker_video_tb;

    import kicker_pkg::*;

    // one frame at two clocks per dot
    localparam int FRAME_CLKS = 2 * 384 * 264;
    localparam int APB_LIMIT  = 200;

    logic        clk;
    logic        rst_n;
    logic        pxl_cen;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [10:0] paddr;
    logic [7:0]  pwdata;
    logic [7:0]  prdata;
    logic        pready;
    logic        pslverr;
    logic [3:0]  pixel;
    video_pos_t  pos;
    logic        lhbl;
    logic        lvbl;
    logic        lhbl_dly;
    logic        lvbl_dly;
    logic        v16;

    // RAM contents as last written over APB
    logic [7:0] shadow [0:`KICKER_VRAM_WORDS-1];

    kicker_video UUT (.*);

    always #20 clk = ~clk;

    // pixel enable on every second clock
    always @(posedge clk) begin
        #2;
        pxl_cen = ~pxl_cen;
    end

    // next clock, just past the edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("MISMATCH time %0t %s got 0x%02h expected 0x%02h",
                                      $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("MISMATCH time %0t %s got %b expected %b",
                                      $time, name, got, exp));
        end
    endtask

    task automatic check_pos(input video_pos_t got, input video_pos_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("MISMATCH time %0t pos got h=%0d v=%0d expected h=%0d v=%0d",
                                      $time, got.h, got.v, exp.h, exp.v));
        end
    endtask

    task automatic check_pixel(input video_pos_t p, input logic [3:0] got,
                               input logic [3:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("MISMATCH time %0t pixel at h=%0d v=%0d got %0d expected %0d",
                                      $time, p.h, p.v, got, exp));
        end
    endtask

    // visible dots 0..255, visible lines 19..235
    function automatic logic h_active(input logic [8:0] h);
        return h <= `KICKER_HB_START;
    endfunction

    function automatic logic v_active(input logic [8:0] v);
        return (v >= `KICKER_VB_END) && (v < `KICKER_VB_START);
    endfunction

    // beam position one pixel enable later
    function automatic video_pos_t next_pos(input video_pos_t p);
        video_pos_t n;
        n = p;
        if (p.h == `KICKER_HCNT_END) begin
            n.h = 9'd0;
            n.v = (p.v == `KICKER_VCNT_END) ? 9'd0 : p.v + 9'd1;
        end else begin
            n.h = p.h + 9'd1;
        end
        return n;
    endfunction

    // colour of a dot from the map word and the pattern row
    function automatic logic [3:0] expect_pixel(input video_pos_t p);
        tile_attr_t attr;
        logic [7:0] row;
        int         map_addr;
        int         pat_addr;
        if (!h_active(p.h) || !v_active(p.v)) begin
            return 4'd0;
        end
        map_addr = int'(`KICKER_MAP_BASE) + int'(p.v) / 8 * 32 + int'(p.h) / 8;
        attr     = tile_attr_t'(shadow[map_addr]);
        pat_addr = int'(`KICKER_PAT_BASE) + int'(attr.code) * 8 + int'(p.v) % 8;
        row      = shadow[pat_addr];
        // bit 7 is the leftmost dot
        return row[7 - int'(p.h) % 8] ? attr.color : 4'd0;
    endfunction

    // one APB transfer, setup then access until pready
    task automatic apb_xfer(input logic write, input logic [10:0] addr, input logic [7:0] wdata,
                            output logic [7:0] rdata, output logic err);
        int waited;
        waited  = 0;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        step();
        penable = 1'b1;
        while (!pready) begin
            if (waited == APB_LIMIT) begin
                stop_with_error($sformatf("APB access to 0x%03h never got pready", addr));
            end
            step();
            waited++;
        end
        rdata = prdata;
        err   = pslverr;
        // transfer completes on this edge
        step();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [10:0] addr, input logic [7:0] data, output logic err);
        logic [7:0] unused_rd;
        apb_xfer(1'b1, addr, data, unused_rd, err);
    endtask

    task automatic apb_read(input logic [10:0] addr, output logic [7:0] data, output logic err);
        apb_xfer(1'b0, addr, 8'h00, data, err);
    endtask

    task automatic wait_pos(input video_pos_t target);
        int waited;
        waited = 0;
        while (pos !== target) begin
            if (waited == 2 * FRAME_CLKS) begin
                stop_with_error($sformatf("beam never reached h=%0d v=%0d", target.h, target.v));
            end
            step();
            waited++;
        end
    endtask

    task automatic test_reset();
        check_bit("pready", pready, 1'b0);
        check_bit("pslverr", pslverr, 1'b0);
        check_bit("lhbl", lhbl, 1'b1);
        check_bit("lvbl", lvbl, 1'b1);
        check_pos(pos, '{h: 9'd0, v: 9'd0});
    endtask

    // random bytes over map and patterns, read back while video fetches
    task automatic test_ram_access();
        logic [10:0] addr [0:27];
        logic [7:0]  data [0:27];
        logic [7:0]  rd;
        logic [7:0]  zero_byte;
        logic [10:0] bad;
        logic        err;
        for (int i = 0; i < 28; i++) begin
            // one address per 41-word slice keeps them distinct
            addr[i] = 11'(i * 41 + $urandom % 41);
            data[i] = 8'($urandom);
            apb_write(addr[i], data[i], err);
            check_bit("pslverr", err, 1'b0);
        end
        for (int i = 0; i < 28; i++) begin
            apb_read(addr[i], rd, err);
            check_bit("pslverr", err, 1'b0);
            check_byte($sformatf("prdata[0x%03h]", addr[i]), rd, data[i]);
        end
        // out of range leaves the RAM alone
        zero_byte = 8'($urandom);
        apb_write(11'd0, zero_byte, err);
        bad = 11'(1152 + $urandom % 896);
        apb_write(bad, ~zero_byte, err);
        check_bit("pslverr", err, 1'b1);
        apb_read(bad, rd, err);
        check_bit("pslverr", err, 1'b1);
        apb_read(11'd0, rd, err);
        check_bit("pslverr", err, 1'b0);
        check_byte("prdata[0x000]", rd, zero_byte);
    endtask

    // follow the beam for a frame and a bit
    task automatic test_frame_timing();
        video_pos_t prev;
        int         moves;
        logic       hb1;
        logic       hb2;
        logic       vb1;
        logic       vb2;
        logic       saw_hwrap;
        logic       saw_vwrap;
        prev      = pos;
        moves     = 0;
        hb1       = lhbl;
        vb1       = lvbl;
        hb2       = 1'b1;
        vb2       = 1'b1;
        saw_hwrap = 1'b0;
        saw_vwrap = 1'b0;
        for (int i = 0; i < FRAME_CLKS + 1000; i++) begin
            step();
            if (pos !== prev) begin
                check_pos(pos, next_pos(prev));
                check_bit("lhbl", lhbl, h_active(pos.h));
                check_bit("lvbl", lvbl, v_active(pos.v));
                check_bit("v16", v16, pos.v[4]);
                // copies lag by two enables
                if (moves >= 1) begin
                    check_bit("lhbl_dly", lhbl_dly, hb2);
                    check_bit("lvbl_dly", lvbl_dly, vb2);
                end
                if (prev.h == `KICKER_HCNT_END) begin
                    saw_hwrap = 1'b1;
                    if (prev.v == `KICKER_VCNT_END) begin
                        saw_vwrap = 1'b1;
                    end
                end
                hb2   = hb1;
                vb2   = vb1;
                hb1   = lhbl;
                vb1   = lvbl;
                prev  = pos;
                moves++;
            end
        end
        if (!saw_hwrap || !saw_vwrap) begin
            stop_with_error("beam did not wrap both line and frame within one frame time");
        end
    endtask

    // random map and patterns, then one whole frame compared dot by dot
    task automatic test_tile_render();
        logic err;
        int   i;
        // map rows 0..29 cover every visible line
        for (i = 0; i < 30 * 32; i++) begin
            shadow[i] = 8'($urandom);
            apb_write(11'(i), shadow[i], err);
            check_bit("pslverr", err, 1'b0);
        end
        // all 16 patterns, 8 rows each
        for (i = 0; i < 16 * 8; i++) begin
            shadow[int'(`KICKER_PAT_BASE) + i] = 8'($urandom);
            apb_write(11'(int'(`KICKER_PAT_BASE) + i), shadow[int'(`KICKER_PAT_BASE) + i], err);
            check_bit("pslverr", err, 1'b0);
        end
        wait_pos('{h: 9'd0, v: 9'd0});
        for (i = 0; i < FRAME_CLKS; i++) begin
            check_pixel(pos, pixel, expect_pixel(pos));
            step();
        end
    endtask

    initial begin
        void'($urandom(31668));
        clk     = 1'b0;
        rst_n   = 1'b0;
        pxl_cen = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        test_reset();
        test_ram_access();
        test_frame_timing();
        test_tile_render();
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/kicker_video_asserts.sv */
// kicker video assertions
`timescale 1ns/10ps
`default_nettype none

module kicker_video_asserts (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   psel,
    input logic                   penable,
    input logic                   pready,
    input logic [10:0]            paddr,
    input logic                   vid_gnt,
    input logic                   cpu_gnt,
    input logic                   v16,
    input kicker_pkg::video_pos_t pos
);

    // address held while the access phase waits
    apb_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && penable && !pready) |=> $stable(paddr))
        else $error("paddr changed while an APB access was waiting");

    // completion strobe is a single cycle
    apb_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        pready |=> !pready)
        else $error("pready stayed high for more than one cycle");

    // one RAM user per cycle
    arb_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(vid_gnt && cpu_gnt))
        else $error("fetcher and CPU were granted in the same cycle");

    // line strobe follows bit 4 of the line count
    v16_is_v4: assert property (@(posedge clk) disable iff (!rst_n)
        v16 == pos.v[4])
        else $error("v16 does not follow bit 4 of the line count");

endmodule

bind kicker_video kicker_video_asserts u_asserts (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .paddr   (paddr),
    .vid_gnt (vid_gnt),
    .cpu_gnt (cpu_gnt),
    .v16     (v16),
    .pos     (pos)
);

`default_nettype wire

/* source/kicker_video.sv */
// kicker video top
`timescale 1ns/10ps
`default_nettype none

module kicker_video (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pxl_cen,
    // APB slave
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [10:0]            paddr,
    input  logic [7:0]             pwdata,
    output logic [7:0]             prdata,
    output logic                   pready,
    output logic                   pslverr,
    // video out
    output logic [3:0]             pixel,
    output kicker_pkg::video_pos_t pos,
    output logic                   lhbl,
    output logic                   lvbl,
    output logic                   lhbl_dly,
    output logic                   lvbl_dly,
    output logic                   v16
);

    import kicker_pkg::*;

    logic       vid_req;
    logic       vid_gnt;
    vram_req_t  vid_cmd;
    logic       cpu_req;
    logic       cpu_gnt;
    vram_req_t  cpu_cmd;
    logic [7:0] rdata;
    logic [3:0] tile_pixel;

    kicker_vtimer u_vtimer (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .pos      (pos),
        .lhbl     (lhbl),
        .lvbl     (lvbl),
        .lhbl_dly (lhbl_dly),
        .lvbl_dly (lvbl_dly),
        .v16      (v16)
    );

    kicker_tilemap u_tilemap (
        .clk     (clk),
        .rst_n   (rst_n),
        .pxl_cen (pxl_cen),
        .pos     (pos),
        .vid_req (vid_req),
        .vid_cmd (vid_cmd),
        .vid_gnt (vid_gnt),
        .rdata   (rdata),
        .pixel   (tile_pixel)
    );

    kicker_apb_vram u_apb (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cpu_req (cpu_req),
        .cpu_cmd (cpu_cmd),
        .cpu_gnt (cpu_gnt),
        .rdata   (rdata)
    );

    kicker_vram_arb u_arb (
        .clk     (clk),
        .rst_n   (rst_n),
        .vid_req (vid_req),
        .cpu_req (cpu_req),
        .vid_cmd (vid_cmd),
        .cpu_cmd (cpu_cmd),
        .vid_gnt (vid_gnt),
        .cpu_gnt (cpu_gnt),
        .rdata   (rdata)
    );

    // black outside the visible area
    assign pixel = (lhbl && lvbl) ? tile_pixel : 4'd0;

endmodule

`default_nettype wire

/* source/kicker_tilemap.sv */
// tile layer
`timescale 1ns/10ps
`include "kicker_consts.svh"
`default_nettype none

module kicker_tilemap (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pxl_cen,
    input  kicker_pkg::video_pos_t pos,
    output logic                   vid_req,
    output kicker_pkg::vram_req_t  vid_cmd,
    input  logic                   vid_gnt,
    input  logic [7:0]             rdata,
    output logic [3:0]             pixel
);

    import kicker_pkg::*;

    fetch_state_t state;
    tile_attr_t   attr_in;
    logic         gnt_q;
    logic [5:0]   tile_c;
    logic [8:0]   tile_v;
    logic [2:0]   row_y;
    logic [3:0]   tile_color;
    logic [7:0]   hold_row;
    logic [3:0]   hold_color;
    logic [7:0]   shift;
    logic [3:0]   color;
    logic         fetch_go;
    logic         load_go;

    // map word as returned by the RAM
    assign attr_in = rdata;

    // fetch starts on the first dot of a tile, load on its last
    assign fetch_go = pxl_cen && (pos.h[2:0] == 3'd0);
    assign load_go  = (pos.h[2:0] == 3'd7);

    // the column one tile ahead of the beam
    // past the last column it is the first tile of the next line
    always_comb begin
        tile_c = pos.h[8:3] + 6'd1;
        tile_v = pos.v;
        if (pos.h[8:3] == 6'((`KICKER_HCNT_END) >> 3)) begin
            tile_c = 6'd0;
            tile_v = (pos.v == `KICKER_VCNT_END) ? 9'd0 : pos.v + 9'd1;
        end
    end

    // fetch FSM, map word first and then the pattern row
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= FETCH_IDLE;
            vid_req <= 1'b0;
            gnt_q   <= 1'b0;
        end else begin
            gnt_q <= vid_gnt;
            if (vid_gnt) begin
                vid_req <= 1'b0;
            end
            case (state)
                FETCH_IDLE: begin
                    if (fetch_go) begin
                        vid_req <= 1'b1;
                        state   <= FETCH_MAP;
                    end
                end
                FETCH_MAP: begin
                    if (gnt_q) begin
                        vid_req <= 1'b1;
                        state   <= FETCH_PAT;
                    end
                end
                FETCH_PAT: begin
                    if (gnt_q) begin
                        state <= FETCH_IDLE;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
        end
    end

    // request addresses and fetched data
    always_ff @(posedge clk) begin
        if (state == FETCH_IDLE && fetch_go) begin
            // 32 map words per tile row
            vid_cmd <= '{addr: `KICKER_MAP_BASE + {tile_v[8:3], tile_c[4:0]},
                         we: 1'b0, wdata: 8'h00};
            row_y   <= tile_v[2:0];
        end
        if (state == FETCH_MAP && gnt_q) begin
            // 8 rows per pattern
            vid_cmd    <= '{addr: `KICKER_PAT_BASE + {4'd0, attr_in.code, row_y},
                            we: 1'b0, wdata: 8'h00};
            tile_color <= attr_in.color;
        end
        if (state == FETCH_PAT && gnt_q) begin
            hold_row   <= rdata;
            hold_color <= tile_color;
        end
    end

    // pixel shifter, bit 7 is the dot under the beam
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            shift <= 8'h00;
        end else if (pxl_cen) begin
            shift <= load_go ? hold_row : {shift[6:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (pxl_cen && load_go) begin
            color <= hold_color;
        end
    end

    assign pixel = shift[7] ? color : 4'd0;

endmodule

`default_nettype wire

/* source/kicker_apb_vram.sv */
// APB video RAM port
`timescale 1ns/10ps
`include "kicker_consts.svh"
`default_nettype none

module kicker_apb_vram (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [10:0]           paddr,
    input  logic [7:0]            pwdata,
    output logic [7:0]            prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic                  cpu_req,
    output kicker_pkg::vram_req_t cpu_cmd,
    input  logic                  cpu_gnt,
    input  logic [7:0]            rdata
);

    import kicker_pkg::*;

    apb_state_t state;
    // grant seen, RAM data arrives this cycle
    logic       gnt_seen;
    logic       setup;
    logic       bad_addr;

    assign setup    = psel && !penable;
    assign bad_addr = (paddr >= `KICKER_VRAM_WORDS);

    // address and data are stable through the access phase
    assign cpu_cmd = '{addr: paddr, we: pwrite, wdata: pwdata};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= APB_IDLE;
            cpu_req  <= 1'b0;
            gnt_seen <= 1'b0;
            pready   <= 1'b0;
            pslverr  <= 1'b0;
        end else begin
            // completion strobes are single-cycle
            pready  <= 1'b0;
            pslverr <= 1'b0;
            case (state)
                APB_IDLE: begin
                    if (setup && bad_addr) begin
                        // out of range, finish in the first access cycle
                        pready  <= 1'b1;
                        pslverr <= 1'b1;
                    end else if (setup) begin
                        cpu_req <= 1'b1;
                        state   <= APB_WAIT;
                    end
                end
                APB_WAIT: begin
                    if (cpu_gnt) begin
                        cpu_req  <= 1'b0;
                        gnt_seen <= 1'b1;
                    end
                    if (gnt_seen) begin
                        gnt_seen <= 1'b0;
                        pready   <= 1'b1;
                        state    <= APB_IDLE;
                    end
                end
                default: state <= APB_IDLE;
            endcase
        end
    end

    // read data is captured together with pready
    always_ff @(posedge clk) begin
        if (state == APB_WAIT && gnt_seen && !pwrite) begin
            prdata <= rdata;
        end
    end

endmodule

`default_nettype wire

/* source/kicker_vram_arb.sv */
// video RAM with arbiter
`timescale 1ns/10ps
`include "kicker_consts.svh"
`default_nettype none

module kicker_vram_arb (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  vid_req,
    input  logic                  cpu_req,
    input  kicker_pkg::vram_req_t vid_cmd,
    input  kicker_pkg::vram_req_t cpu_cmd,
    output logic                  vid_gnt,
    output logic                  cpu_gnt,
    output logic [7:0]            rdata
);

    import kicker_pkg::*;

    // single-port storage, tile map at the bottom and patterns on top
    logic [7:0] mem [0:`KICKER_VRAM_WORDS-1];
    vram_req_t  cmd;
    logic       access;

    // fixed priority
    // the fetcher always wins, the CPU takes any free cycle
    assign vid_gnt = vid_req;
    assign cpu_gnt = cpu_req && !vid_req;
    assign access  = vid_gnt || cpu_gnt;

    // granted request drives the RAM port
    assign cmd = vid_req ? vid_cmd : cpu_cmd;

    // write port
    always_ff @(posedge clk) begin
        if (access && cmd.we) begin
            mem[cmd.addr] <= cmd.wdata;
        end
    end

    // read data lands the cycle after the grant
    // shared by both requesters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata <= 8'h00;
        end else if (access && !cmd.we) begin
            rdata <= mem[cmd.addr];
        end
    end

endmodule

`default_nettype wire

/* source/kicker_vtimer.sv */
// video beam timer
`timescale 1ns/10ps
`include "kicker_consts.svh"
`default_nettype none

module kicker_vtimer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pxl_cen,
    output kicker_pkg::video_pos_t pos,
    output logic                   lhbl,
    output logic                   lvbl,
    output logic                   lhbl_dly,
    output logic                   lvbl_dly,
    output logic                   v16
);

    logic [8:0]                h_nxt;
    logic [8:0]                v_nxt;
    logic [`KICKER_HB_DLY-1:0] lhbl_sr;
    logic [`KICKER_HB_DLY-1:0] lvbl_sr;

    // next beam position
    // v only moves when h wraps
    always_comb begin
        h_nxt = pos.h + 9'd1;
        v_nxt = pos.v;
        if (pos.h == `KICKER_HCNT_END) begin
            h_nxt = 9'd0;
            v_nxt = (pos.v == `KICKER_VCNT_END) ? 9'd0 : pos.v + 9'd1;
        end
    end

    // counters and blanking flags
    // flags are decoded from the next count so they stay aligned with pos
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pos  <= '0;
            lhbl <= 1'b1;
            lvbl <= 1'b1;
        end else if (pxl_cen) begin
            pos.h <= h_nxt;
            pos.v <= v_nxt;
            lhbl  <= (h_nxt <= `KICKER_HB_START);
            // active lines 19..235
            lvbl  <= (v_nxt >= `KICKER_VB_END) && (v_nxt < `KICKER_VB_START);
        end
    end

    // delayed blanking copies, shifted on the pixel enable
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lhbl_sr <= '1;
            lvbl_sr <= '1;
        end else if (pxl_cen) begin
            lhbl_sr <= {lhbl_sr[`KICKER_HB_DLY-2:0], lhbl};
            lvbl_sr <= {lvbl_sr[`KICKER_HB_DLY-2:0], lvbl};
        end
    end

    assign lhbl_dly = lhbl_sr[`KICKER_HB_DLY-1];
    assign lvbl_dly = lvbl_sr[`KICKER_HB_DLY-1];

    // 16-line strobe
    assign v16 = pos.v[4];

endmodule

`default_nettype wire

/* source/kicker_pkg.sv */
// kicker video types
`default_nettype none

package kicker_pkg;

    // beam position
    typedef struct packed {
        logic [8:0] h;
        logic [8:0] v;
    } video_pos_t;

    // one video RAM request
    typedef struct packed {
        logic [10:0] addr;
        logic        we;
        logic [7:0]  wdata;
    } vram_req_t;

    // tile map word
    typedef struct packed {
        logic [3:0] color;
        logic [3:0] code;
    } tile_attr_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_MAP,
        FETCH_PAT
    } fetch_state_t;

    typedef enum logic {
        APB_IDLE,
        APB_WAIT
    } apb_state_t;

endpackage

`default_nettype wire

/* source/kicker_consts.svh */
// kicker video constants
`default_nettype none

`ifndef KICKER_CONSTS_SVH
`define KICKER_CONSTS_SVH

// horizontal count, 384 dots per line
`define KICKER_HCNT_END   9'd383
// last visible dot of a line
`define KICKER_HB_START   9'd255
// vertical count, 264 lines per frame
`define KICKER_VCNT_END   9'd263
// vertical blank covers 236..263 and 0..18
`define KICKER_VB_START   9'd236
`define KICKER_VB_END     9'd19

// video RAM map, 8-bit words
`define KICKER_MAP_BASE   11'h000
`define KICKER_PAT_BASE   11'h400
`define KICKER_VRAM_WORDS 11'd1152

// lag of the delayed blanking copies, in pixel enables
`define KICKER_HB_DLY     2

`endif

`default_nettype wire
